// File: Bender.yml
package:
  name: icache

sources:
  - common/icache_pkg.sv
  - hw/victim_select.sv
  - hw/refill_ctrl.sv
  - icache/icache_ways.sv
  - icache/icache_ctrl.sv
  - hw/icache_top.sv
  - target: simulation
    files:
      - sim/tb_clkgen.sv
      - sim/icache_tb.sv

// File: common/icache_pkg.sv
package icache_pkg;

    // geometry, fixed by the address split
    localparam int ADDR_W     = 19;
    localparam int WORD_W     = 32;
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 8;
    localparam int LINE_WORDS = 16;

    // field widths and positions inside a byte address
    localparam int TAG_W      = 10;
    localparam int SET_W      = 3;
    localparam int WIDX_W     = 4;
    localparam int TAG_LSB    = 9;   // tag [18:9]
    localparam int SET_LSB    = 6;   // set [8:6]
    localparam int WIDX_LSB   = 2;   // word [5:2]
    localparam int LINE_LSB   = 6;   // byte offset bits inside a line

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [SET_W-1:0]    set_idx_t;
    typedef logic [WIDX_W-1:0]   word_idx_t;
    typedef logic [NUM_WAYS-1:0] way_mask_t;   // one-hot way
    typedef logic [2:0]          plru_bits_t;  // {right pair, left pair, root}

    // fetch controller
    typedef enum logic [1:0] {
        SLEEP,    // cache off, contents invalid
        IDLE,     // waiting for a fetch
        COMPARE,  // tag compare of the granted fetch
        REFILL    // line coming from next level
    } ctrl_state_t;

endpackage

// File: files.f
common/icache_pkg.sv
hw/victim_select.sv
hw/refill_ctrl.sv
icache/icache_ways.sv
icache/icache_ctrl.sv
hw/icache_top.sv
sim/tb_clkgen.sv
sim/icache_tb.sv

// File: hw/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  fetch_req,
    input  addr_t fetch_addr,
    output logic  fetch_gnt,
    output logic  fetch_r_valid,
    output word_t fetch_r_data,
    output logic  refill_req,
    output addr_t refill_addr,
    input  logic  refill_gnt,
    input  logic  refill_r_valid,
    input  word_t refill_r_data,
    output logic  refill_done,
    input  logic  work_en,
    input  logic  sleep_en
);

    // ctrl <-> ways
    logic      hit, rd_en, wr_en, line_fill, invalidate_all;
    way_mask_t hit_way, set_valid, wr_way;
    word_t     hit_data, wr_data;
    set_idx_t  rd_set, wr_set;
    tag_t      lookup_tag, wr_tag;
    word_idx_t wr_word;

    // ctrl <-> refill
    logic      miss_start, fill_valid, fill_done;
    addr_t     miss_line_addr;
    word_idx_t fill_word;
    word_t     fill_data;

    // ctrl <-> victim select
    logic      touch;
    way_mask_t touch_way, victim_way;

    icache_ctrl icache_ctrl_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_req      (fetch_req),
        .fetch_addr     (fetch_addr),
        .fetch_gnt      (fetch_gnt),
        .fetch_r_valid  (fetch_r_valid),
        .fetch_r_data   (fetch_r_data),
        .work_en        (work_en),
        .sleep_en       (sleep_en),
        .hit            (hit),
        .hit_way        (hit_way),
        .hit_data       (hit_data),
        .rd_set         (rd_set),
        .rd_en          (rd_en),
        .lookup_tag     (lookup_tag),
        .wr_en          (wr_en),
        .wr_way         (wr_way),
        .wr_set         (wr_set),
        .wr_word        (wr_word),
        .wr_data        (wr_data),
        .wr_tag         (wr_tag),
        .line_fill      (line_fill),
        .invalidate_all (invalidate_all),
        .fill_valid     (fill_valid),
        .fill_word      (fill_word),
        .fill_data      (fill_data),
        .fill_done      (fill_done),
        .miss_start     (miss_start),
        .miss_line_addr (miss_line_addr),
        .victim_way     (victim_way),
        .touch          (touch),
        .touch_way      (touch_way)
    );

    icache_ways icache_ways_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_en          (rd_en),
        .rd_set         (rd_set),
        .lookup_tag     (lookup_tag),
        .wr_en          (wr_en),
        .wr_way         (wr_way),
        .wr_set         (wr_set),
        .wr_word        (wr_word),
        .wr_data        (wr_data),
        .wr_tag         (wr_tag),
        .line_fill      (line_fill),
        .invalidate_all (invalidate_all),
        .hit            (hit),
        .hit_way        (hit_way),
        .hit_data       (hit_data),
        .set_valid      (set_valid)
    );

    // set of the current fetch drives both the update and the query
    victim_select victim_select_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .touch      (touch),
        .touch_way  (touch_way),
        .touch_set  (wr_set),
        .set_valid  (set_valid),
        .query_set  (wr_set),
        .victim_way (victim_way)
    );

    refill_ctrl refill_ctrl_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .miss_start     (miss_start),
        .miss_line_addr (miss_line_addr),
        .refill_req     (refill_req),
        .refill_addr    (refill_addr),
        .refill_gnt     (refill_gnt),
        .refill_r_valid (refill_r_valid),
        .refill_r_data  (refill_r_data),
        .refill_done    (refill_done),
        .fill_valid     (fill_valid),
        .fill_word      (fill_word),
        .fill_data      (fill_data),
        .fill_done      (fill_done)
    );

endmodule

// File: hw/refill_ctrl.sv
`timescale 1ns/1ps

module refill_ctrl import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      miss_start,
    input  addr_t     miss_line_addr,
    // next level
    output logic      refill_req,
    output addr_t     refill_addr,
    input  logic      refill_gnt,
    input  logic      refill_r_valid,
    input  word_t     refill_r_data,
    output logic      refill_done,
    // towards the ways
    output logic      fill_valid,
    output word_idx_t fill_word,
    output word_t     fill_data,
    output logic      fill_done
);

    logic      req_q;    // request waiting for grant
    logic      busy_q;   // granted, beats in flight
    word_idx_t cnt_q;
    addr_t     addr_q;
    logic      last_beat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else if (miss_start) begin
            req_q <= 1'b1;
        end else if (refill_gnt) begin
            req_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (req_q && refill_gnt) begin
            busy_q <= 1'b1;
        end else if (last_beat) begin
            busy_q <= 1'b0;
        end
    end

    // beat counter, wraps to zero after word 15
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (fill_valid) begin
            cnt_q <= cnt_q + word_idx_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) addr_q <= miss_line_addr;
    end

    assign refill_req  = req_q;
    assign refill_addr = addr_q;

    assign fill_valid = busy_q && refill_r_valid;
    assign fill_word  = cnt_q;
    assign fill_data  = refill_r_data;

    assign last_beat   = fill_valid && (cnt_q == word_idx_t'(LINE_WORDS - 1));
    assign fill_done   = last_beat;
    assign refill_done = last_beat;

    a_no_beat_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        refill_r_valid |-> busy_q
    );

    // controller must not start a second miss over a running one
    a_miss_when_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        miss_start |-> !(req_q || busy_q)
    );

endmodule

// File: hw/victim_select.sv
`timescale 1ns/1ps

module victim_select import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      touch,
    input  way_mask_t touch_way,
    input  set_idx_t  touch_set,
    input  way_mask_t set_valid,
    input  set_idx_t  query_set,
    output way_mask_t victim_way
);

    plru_bits_t tree_q [NUM_SETS];
    plru_bits_t tree;
    way_mask_t  plru_way;
    way_mask_t  free_way;

    // bits point at the next victim, so a touch flips them away
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) tree_q[s] <= '0;
        end else if (touch) begin
            unique case (1'b1)
                touch_way[0]: begin
                    tree_q[touch_set][0] <= 1'b1;   // right half next
                    tree_q[touch_set][1] <= 1'b1;
                end
                touch_way[1]: begin
                    tree_q[touch_set][0] <= 1'b1;
                    tree_q[touch_set][1] <= 1'b0;
                end
                touch_way[2]: begin
                    tree_q[touch_set][0] <= 1'b0;   // left half next
                    tree_q[touch_set][2] <= 1'b1;
                end
                touch_way[3]: begin
                    tree_q[touch_set][0] <= 1'b0;
                    tree_q[touch_set][2] <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    assign tree = tree_q[query_set];

    always_comb begin
        plru_way = '0;
        if (tree[0]) plru_way[tree[2] ? 3 : 2] = 1'b1;
        else         plru_way[tree[1] ? 1 : 0] = 1'b1;
    end

    // lowest invalid way
    assign free_way = ~set_valid & (set_valid + way_mask_t'(1));

    assign victim_way = (&set_valid) ? plru_way : free_way;

    a_victim_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(victim_way)
    );

endmodule

// File: icache/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // core side
    input  logic      fetch_req,
    input  addr_t     fetch_addr,
    output logic      fetch_gnt,
    output logic      fetch_r_valid,
    output word_t     fetch_r_data,
    input  logic      work_en,
    input  logic      sleep_en,
    // ways
    input  logic      hit,
    input  way_mask_t hit_way,
    input  word_t     hit_data,
    output set_idx_t  rd_set,
    output logic      rd_en,
    output tag_t      lookup_tag,
    output logic      wr_en,
    output way_mask_t wr_way,
    output set_idx_t  wr_set,
    output word_idx_t wr_word,
    output word_t     wr_data,
    output tag_t      wr_tag,
    output logic      line_fill,
    output logic      invalidate_all,
    // refill controller
    input  logic      fill_valid,
    input  word_idx_t fill_word,
    input  word_t     fill_data,
    input  logic      fill_done,
    output logic      miss_start,
    output addr_t     miss_line_addr,
    // replacement
    input  way_mask_t victim_way,
    output logic      touch,
    output way_mask_t touch_way
);

    ctrl_state_t state_q, state_d;
    addr_t       addr_q;     // address of the granted fetch
    way_mask_t   victim_q;   // way being refilled

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= SLEEP;
        end else begin
            state_q <= state_d;
        end
    end

    // captured at every grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (fetch_gnt) begin
            addr_q <= fetch_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_q <= '0;
        end else if (miss_start) begin
            victim_q <= victim_way;   // choice frozen for the whole refill
        end
    end

    always_comb begin
        state_d        = state_q;
        fetch_gnt      = 1'b0;
        fetch_r_valid  = 1'b0;
        fetch_r_data   = '0;
        rd_en          = 1'b0;
        wr_en          = 1'b0;
        line_fill      = 1'b0;
        invalidate_all = 1'b0;
        miss_start     = 1'b0;
        touch          = 1'b0;
        case (state_q)
            SLEEP: begin
                if (work_en) state_d = IDLE;
            end
            IDLE: begin
                if (sleep_en) begin
                    invalidate_all = 1'b1;   // drop every line on the way down
                    state_d        = SLEEP;
                end else if (fetch_req) begin
                    fetch_gnt = 1'b1;
                    rd_en     = 1'b1;        // arrays answer next cycle
                    state_d   = COMPARE;
                end
            end
            COMPARE: begin
                if (hit) begin
                    fetch_r_valid = 1'b1;
                    fetch_r_data  = hit_data;
                    touch         = 1'b1;
                    // pipelined hit: take the next fetch in the same cycle
                    if (fetch_req) begin
                        fetch_gnt = 1'b1;
                        rd_en     = 1'b1;
                    end else begin
                        state_d = IDLE;
                    end
                end else begin
                    miss_start = 1'b1;
                    state_d    = REFILL;
                end
            end
            REFILL: begin
                if (fill_valid) begin
                    wr_en = 1'b1;
                    // requested word goes straight to the core
                    if (fill_word == addr_q[WIDX_LSB +: WIDX_W]) begin
                        fetch_r_valid = 1'b1;
                        fetch_r_data  = fill_data;
                    end
                end
                if (fill_done) begin
                    line_fill = 1'b1;   // tag + valid of the new line
                    touch     = 1'b1;
                    state_d   = IDLE;
                end
            end
            default: state_d = SLEEP;
        endcase
    end

    assign rd_set     = fetch_addr[SET_LSB +: SET_W];
    assign lookup_tag = addr_q[TAG_LSB +: TAG_W];     // compared one cycle after the read
    assign wr_set     = addr_q[SET_LSB +: SET_W];
    assign wr_tag     = addr_q[TAG_LSB +: TAG_W];
    assign wr_way     = victim_q;
    assign wr_data    = fill_data;

    // data store has a single word address, shared by read and write
    assign wr_word = (state_q == REFILL) ? fill_word : fetch_addr[WIDX_LSB +: WIDX_W];

    assign miss_line_addr = {addr_q[ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
    assign touch_way      = (state_q == REFILL) ? victim_q : hit_way;

    a_no_rvalid_in_sleep: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == SLEEP) |-> !fetch_r_valid
    );

endmodule

// File: icache/icache_ways.sv
`timescale 1ns/1ps

module icache_ways import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rd_en,
    input  set_idx_t  rd_set,
    input  tag_t      lookup_tag,
    input  logic      wr_en,
    input  way_mask_t wr_way,
    input  set_idx_t  wr_set,
    input  word_idx_t wr_word,     // also the read word, see ctrl
    input  word_t     wr_data,
    input  tag_t      wr_tag,
    input  logic      line_fill,
    input  logic      invalidate_all,
    output logic      hit,
    output way_mask_t hit_way,
    output word_t     hit_data,
    output way_mask_t set_valid
);

    tag_t      tag_mem  [NUM_WAYS][NUM_SETS];
    word_t     data_mem [NUM_WAYS][NUM_SETS*LINE_WORDS];
    way_mask_t valid_q  [NUM_SETS];

    set_idx_t  rd_set_q;
    word_idx_t rd_word_q;

    // read index, registered so lookups land one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_set_q  <= '0;
            rd_word_q <= '0;
        end else if (rd_en) begin
            rd_set_q  <= rd_set;
            rd_word_q <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (wr_en && wr_way[w]) begin
                data_mem[w][{wr_set, wr_word}] <= wr_data;
            end
            if (line_fill && wr_way[w]) begin
                tag_mem[w][wr_set] <= wr_tag;   // tag only once the line is whole
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) valid_q[s] <= '0;
        end else if (invalidate_all) begin
            for (int s = 0; s < NUM_SETS; s++) valid_q[s] <= '0;
        end else if (line_fill) begin
            valid_q[wr_set] <= valid_q[wr_set] | wr_way;
        end
    end

    // compare all four ways of the set read last cycle
    always_comb begin
        hit_data = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_way[w] = valid_q[rd_set_q][w] && (tag_mem[w][rd_set_q] == lookup_tag);
            if (hit_way[w]) hit_data = hit_data | data_mem[w][{rd_set_q, rd_word_q}];
        end
    end

    assign hit       = |hit_way;
    assign set_valid = valid_q[rd_set_q];   // victim choice for this set

    // a line can live in one way only, else a refill chose badly
    a_hit_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(hit_way)
    );

endmodule

// File: sim/icache_tb.sv
`timescale 1ns/1ps

module icache_tb import icache_pkg::*;;

    // 8 misses of at most ~40 cycles plus a few dozen hits stay below 600 cycles
    localparam int MAX_CYCLES = 4000;

    logic  clk, rst_n;
    logic  fetch_req, fetch_gnt, fetch_r_valid;
    addr_t fetch_addr;
    word_t fetch_r_data;
    logic  refill_req, refill_gnt, refill_r_valid, refill_done;
    addr_t refill_addr;
    word_t refill_r_data;
    logic  work_en, sleep_en;

    logic       cache_on;      // work_en given, no sleep since
    logic       expect_hit;    // current fetch must hit
    logic       expect_miss;   // current fetch must miss
    logic       mem_busy;      // next-level model serving a line
    logic       mem_last;      // last beat of the line on the bus
    logic [7:0] lfsr = 8'd81;
    int         errors = 0;
    int         cycles = 0;
    int         n_fetch = 0;
    int         n_refill = 0;
    string      test_name;

    // scoreboard of granted addresses, oldest first
    addr_t      exp_q [16];
    logic [3:0] wr_ptr, rd_ptr, pending;
    addr_t      last_gnt_addr;
    word_t      exp_rdata;
    addr_t      exp_line;

    tb_clkgen tb_clkgen_inst (.clk(clk), .rst_n(rst_n));

    icache_top icache_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_req      (fetch_req),
        .fetch_addr     (fetch_addr),
        .fetch_gnt      (fetch_gnt),
        .fetch_r_valid  (fetch_r_valid),
        .fetch_r_data   (fetch_r_data),
        .refill_req     (refill_req),
        .refill_addr    (refill_addr),
        .refill_gnt     (refill_gnt),
        .refill_r_valid (refill_r_valid),
        .refill_r_data  (refill_r_data),
        .refill_done    (refill_done),
        .work_en        (work_en),
        .sleep_en       (sleep_en)
    );

    // memory content: byte address of the word, inverted, zero on top
    function automatic word_t mem_word(input addr_t a);
        return {{(WORD_W-ADDR_W){1'b0}}, ~a};
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return {a[ADDR_W-1:6], 6'b0};
    endfunction

    function automatic addr_t make_addr(input tag_t t, input set_idx_t s, input word_idx_t w);
        return {t, s, w, 2'b00};
    endfunction

    // taps 8,6,5,4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);   // one step per bit
        end
    endtask

    task automatic report_mismatch(input string what, input word_t exp, input word_t act);
        errors++;
        $display("FAIL %s/%s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("error in %s: %s", test_name, msg);
    endtask

    task automatic print_counts();
        $display("fetches %0d, refills %0d, cycles %0d, errors %0d",
                 n_fetch, n_refill, cycles, errors);
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            last_gnt_addr <= '0;
        end else begin
            if (fetch_req && fetch_gnt) begin
                exp_q[wr_ptr] <= fetch_addr;
                wr_ptr        <= wr_ptr + 4'd1;
                last_gnt_addr <= fetch_addr;
                n_fetch++;
            end
            if (fetch_r_valid) rd_ptr <= rd_ptr + 4'd1;
        end
    end

    assign pending   = wr_ptr - rd_ptr;
    assign exp_rdata = mem_word(exp_q[rd_ptr]);
    assign exp_line  = line_of(last_gnt_addr);

    // next level: grant after 0..3 cycles, 16 beats with 0..1 cycle gaps
    initial begin : next_level
        int    delay;
        int    gap;
        addr_t line;
        refill_gnt     <= 1'b0;
        refill_r_valid <= 1'b0;
        refill_r_data  <= '0;
        mem_busy       <= 1'b0;
        mem_last       <= 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n && refill_req) begin
                mem_busy <= 1'b1;
                draw_bits(2, delay);
                repeat (delay) @(posedge clk);
                line = refill_addr;
                refill_gnt <= 1'b1;
                @(posedge clk);
                refill_gnt <= 1'b0;
                for (int i = 0; i < LINE_WORDS; i++) begin
                    draw_bits(1, gap);
                    if (gap != 0) begin
                        refill_r_valid <= 1'b0;
                        @(posedge clk);
                    end
                    refill_r_valid <= 1'b1;
                    refill_r_data  <= mem_word(line + addr_t'(4 * i));   // word 0 first
                    mem_last       <= (i == LINE_WORDS - 1);
                    @(posedge clk);
                end
                refill_r_valid <= 1'b0;
                mem_last       <= 1'b0;
                mem_busy       <= 1'b0;
                n_refill++;
            end
        end
    end

    a_sleep_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !cache_on |-> !fetch_gnt && !fetch_r_valid && !refill_req)
        else report_problem("cache answered while asleep");

    a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_gnt |-> fetch_req)
        else report_problem("grant without a request");

    a_rvalid_owned: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_r_valid |-> pending != 4'd0)
        else report_problem("read-valid without an open grant");

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_r_valid |-> fetch_r_data == exp_rdata)
        else report_mismatch("rdata", $sampled(exp_rdata), $sampled(fetch_r_data));

    a_refill_addr: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(refill_req) |-> refill_addr == exp_line)
        else report_mismatch("refill_addr", word_t'($sampled(exp_line)),
                             word_t'($sampled(refill_addr)));

    // done pulses with the 16th beat and at no other time
    a_refill_done: assert property (@(posedge clk) disable iff (!rst_n)
        refill_done == (refill_r_valid && mem_last))
        else report_mismatch("refill_done", word_t'($sampled(refill_r_valid && mem_last)),
                             word_t'($sampled(refill_done)));

    a_hit_no_refill: assert property (@(posedge clk) disable iff (!rst_n)
        expect_hit |-> !refill_req)
        else report_problem("refill request on a fetch that should hit");

    // hit answers in the very next cycle, also inside a stream
    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        expect_hit && fetch_req && fetch_gnt |=> fetch_r_valid)
        else report_problem("hit not answered one cycle after its grant");

    a_miss_refill: assert property (@(posedge clk) disable iff (!rst_n)
        expect_miss && fetch_req && fetch_gnt |-> ##[1:2] refill_req)
        else report_problem("no refill request after a missing fetch");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("timeout: run still going after %0d cycles", cycles);
            print_counts();
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic wake();
        work_en  <= 1'b1;
        cache_on <= 1'b1;
        @(posedge clk);
        work_en  <= 1'b0;
    endtask

    // request already driven; wait grant, answer and end of any refill
    task automatic finish_fetch();
        do @(posedge clk); while (!(fetch_req && fetch_gnt));
        fetch_req <= 1'b0;
        do @(posedge clk); while (!fetch_r_valid);
        while (mem_busy) @(posedge clk);
        expect_hit  <= 1'b0;
        expect_miss <= 1'b0;
    endtask

    task automatic fetch_one(input addr_t a, input bit is_hit);
        fetch_req   <= 1'b1;
        fetch_addr  <= a;
        expect_hit  <= is_hit;
        expect_miss <= !is_hit;
        finish_fetch();
    endtask

    // req held high, address stepped on every grant
    task automatic stream_hits(input addr_t base, input int n);
        int granted;
        int returned;
        granted  = 0;
        returned = 0;
        expect_hit <= 1'b1;
        fetch_req  <= 1'b1;
        fetch_addr <= base;
        while (returned < n) begin
            @(posedge clk);
            if (fetch_r_valid) returned++;
            if (fetch_req && fetch_gnt) begin
                granted++;
                if (granted == n) fetch_req <= 1'b0;
                else              fetch_addr <= base + addr_t'(4 * granted);
            end
        end
        expect_hit <= 1'b0;
    endtask

    initial begin : main
        fetch_req   <= 1'b0;
        fetch_addr  <= '0;
        work_en     <= 1'b0;
        sleep_en    <= 1'b0;
        cache_on    <= 1'b0;
        expect_hit  <= 1'b0;
        expect_miss <= 1'b0;
        test_name = "reset_sleep";
        while (rst_n !== 1'b1) @(posedge clk);

        // request pending in SLEEP, nothing may move
        fetch_req   <= 1'b1;
        fetch_addr  <= make_addr(10'h011, 3'd0, 4'd5);
        expect_miss <= 1'b1;
        repeat (4) @(posedge clk);

        test_name = "miss";
        wake();
        finish_fetch();

        test_name = "hit";
        fetch_one(make_addr(10'h011, 3'd0, 4'd0), 1'b1);
        fetch_one(make_addr(10'h011, 3'd0, 4'd15), 1'b1);
        stream_hits(make_addr(10'h011, 3'd0, 4'd2), 8);

        // tags A..D fill ways 0..3 of set 5, E then replaces A
        test_name = "replace";
        fetch_one(make_addr(10'h0a0, 3'd5, 4'd1), 1'b0);
        fetch_one(make_addr(10'h0b0, 3'd5, 4'd2), 1'b0);
        fetch_one(make_addr(10'h0c0, 3'd5, 4'd3), 1'b0);
        fetch_one(make_addr(10'h0d0, 3'd5, 4'd4), 1'b0);
        fetch_one(make_addr(10'h0e0, 3'd5, 4'd9), 1'b0);
        fetch_one(make_addr(10'h0c0, 3'd5, 4'd7), 1'b1);
        fetch_one(make_addr(10'h0d0, 3'd5, 4'd8), 1'b1);
        fetch_one(make_addr(10'h0a0, 3'd5, 4'd1), 1'b0);   // A was evicted

        test_name = "sleep";
        sleep_en <= 1'b1;
        cache_on <= 1'b0;
        @(posedge clk);
        sleep_en    <= 1'b0;
        fetch_req   <= 1'b1;
        fetch_addr  <= make_addr(10'h011, 3'd0, 4'd5);   // cached before the sleep
        expect_miss <= 1'b1;
        repeat (3) @(posedge clk);
        wake();
        finish_fetch();

        repeat (3) @(posedge clk);
        a_all_answered: assert (pending == 4'd0)
            else report_problem("grants left without a read-valid");
        print_counts();
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    localparam real HALF_PERIOD = 50.0;   // 100 ns clock

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset held over the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule
